// ==== source/dcache_cfg.svh ====
////////////////////////////////////////
// dcache geometry
// address split and way count for the
// two-way write-back data cache
////////////////////////////////////////

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

`define DCACHE_ADDR_W   32
`define DCACHE_DATA_W   64
`define DCACHE_STRB_W   8

// 64 sets of one word each
`define DCACHE_INDEX_W  6
`define DCACHE_OFFSET_W 3
`define DCACHE_TAG_W    (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

`define DCACHE_WAYS     2
`define DCACHE_WAY_W    1

`endif

// ==== source/dcache_pkg.sv ====
////////////////////////////////////////
// dcache types
// address views and controller states
////////////////////////////////////////

`include "dcache_cfg.svh"

package dcache_pkg;

    // tag | index | byte offset
    typedef struct packed {
        logic [`DCACHE_TAG_W-1:0]    tag;
        logic [`DCACHE_INDEX_W-1:0]  index;
        logic [`DCACHE_OFFSET_W-1:0] offset;
    } addr_fields_t;

    // one address word, seen raw on the bus or split for array access
    typedef union packed {
        logic [`DCACHE_ADDR_W-1:0] raw;
        addr_fields_t              fields;
    } addr_u;

    // request controller states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        LOOKUP = 2'd1,
        HIT    = 2'd2,
        MISS   = 2'd3
    } ctrl_state_e;

endpackage

// ==== source/store_if.sv ====
////////////////////////////////////////
// controller to way store link
// lookup, hit write, refill, recency
////////////////////////////////////////

`timescale 1ns/1ps
`include "dcache_cfg.svh"

interface store_if import dcache_pkg::*; ();

    logic                      lk_valid;
    addr_u                     lk_addr;
    logic                      wr_en;
    logic [`DCACHE_WAY_W-1:0]  wr_way;
    logic [`DCACHE_STRB_W-1:0] wr_strb;
    logic [`DCACHE_DATA_W-1:0] wr_data;
    logic                      fill_en;
    logic [`DCACHE_DATA_W-1:0] fill_data;
    logic                      touch;

    // registered lookup result
    logic                      rd_done;
    logic                      hit;
    logic [`DCACHE_WAY_W-1:0]  hit_way;
    logic [`DCACHE_DATA_W-1:0] rd_data;
    logic [`DCACHE_WAY_W-1:0]  victim_way;
    logic                      victim_dirty;
    logic [`DCACHE_TAG_W-1:0]  victim_tag;
    logic [`DCACHE_DATA_W-1:0] victim_data;

    modport ctrl (
        output lk_valid, lk_addr, wr_en, wr_way, wr_strb, wr_data,
        output fill_en, fill_data, touch,
        input  rd_done, hit, hit_way, rd_data,
        input  victim_way, victim_dirty, victim_tag, victim_data
    );

    modport store (
        input  lk_valid, lk_addr, wr_en, wr_way, wr_strb, wr_data,
        input  fill_en, fill_data, touch,
        output rd_done, hit, hit_way, rd_data,
        output victim_way, victim_dirty, victim_tag, victim_data
    );

endinterface

// ==== source/mem_job_if.sv ====
////////////////////////////////////////
// controller to memory port link
// one miss job per handshake
////////////////////////////////////////

`timescale 1ns/1ps
`include "dcache_cfg.svh"

interface mem_job_if import dcache_pkg::*; ();

    logic                      job_valid;
    logic                      job_ready;
    // line to refill
    addr_u                     job_addr;
    // dirty victim, written back first
    logic                      wb_needed;
    addr_u                     wb_addr;
    logic [`DCACHE_DATA_W-1:0] wb_data;
    logic                      job_done;
    logic [`DCACHE_DATA_W-1:0] fill_data;

    modport ctrl (
        output job_valid, job_addr, wb_needed, wb_addr, wb_data,
        input  job_ready, job_done, fill_data
    );

    modport port (
        input  job_valid, job_addr, wb_needed, wb_addr, wb_data,
        output job_ready, job_done, fill_data
    );

endinterface

// ==== source/way_store.sv ====
////////////////////////////////////////
// dcache way store
// tags, state and data of both ways
// with a one cycle registered lookup
////////////////////////////////////////

`timescale 1ns/1ps
`include "dcache_cfg.svh"

module way_store (
    input  logic   clk,
    input  logic   arst_n_i,
    store_if.store store
);

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    logic [`DCACHE_TAG_W-1:0]   tag_q   [`DCACHE_WAYS][SETS];
    logic [`DCACHE_DATA_W-1:0]  data_q  [`DCACHE_WAYS][SETS];
    logic [SETS-1:0]            valid_q [`DCACHE_WAYS];
    logic [SETS-1:0]            dirty_q [`DCACHE_WAYS];
    // most recently used way of each set
    logic [SETS-1:0]            mru_q;

    logic [`DCACHE_INDEX_W-1:0] idx;
    logic [`DCACHE_TAG_W-1:0]   tag;
    logic [`DCACHE_WAYS-1:0]    way_hit;
    logic [`DCACHE_WAY_W-1:0]   victim;

    assign idx = store.lk_addr.fields.index;
    assign tag = store.lk_addr.fields.tag;

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_hit[w] = valid_q[w][idx] && (tag_q[w][idx] == tag);
        end
    end

    // an empty way first, else the older one
    always_comb begin
        if (!valid_q[0][idx]) begin
            victim = 1'b0;
        end else if (!valid_q[1][idx]) begin
            victim = 1'b1;
        end else begin
            victim = ~mru_q[idx];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            store.rd_done <= 1'b0;
        end else begin
            store.rd_done <= store.lk_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (store.lk_valid) begin
            store.hit          <= |way_hit;
            store.hit_way      <= way_hit[1];
            store.rd_data      <= data_q[way_hit[1]][idx];
            store.victim_way   <= victim;
            store.victim_dirty <= valid_q[victim][idx] && dirty_q[victim][idx];
            store.victim_tag   <= tag_q[victim][idx];
            store.victim_data  <= data_q[victim][idx];
        end
    end

    // refill goes to the victim picked at the last lookup
    always_ff @(posedge clk) begin
        if (store.fill_en) begin
            tag_q[store.victim_way][idx]  <= tag;
            data_q[store.victim_way][idx] <= store.fill_data;
        end else if (store.wr_en) begin
            for (int b = 0; b < `DCACHE_STRB_W; b++) begin
                if (store.wr_strb[b]) begin
                    data_q[store.wr_way][idx][8*b +: 8] <= store.wr_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            mru_q <= '0;
        end else begin
            if (store.fill_en) begin
                valid_q[store.victim_way][idx] <= 1'b1;
                dirty_q[store.victim_way][idx] <= 1'b0;
            end
            if (store.wr_en) begin
                dirty_q[store.wr_way][idx] <= 1'b1;
            end
            if (store.touch) begin
                mru_q[idx] <= store.hit_way;
            end
        end
    end

endmodule

// ==== source/mem_port.sv ====
////////////////////////////////////////
// dcache memory port
// runs a miss job as an optional
// writeback beat, then a refill beat
////////////////////////////////////////

`timescale 1ns/1ps
`include "dcache_cfg.svh"

module mem_port import dcache_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n_i,
    mem_job_if.port                   job,
    output logic                      mem_valid_o,
    output logic                      mem_write_o,
    output logic [`DCACHE_ADDR_W-1:0] mem_addr_o,
    output logic [`DCACHE_DATA_W-1:0] mem_wdata_o,
    input  logic                      mem_ready_i,
    input  logic [`DCACHE_DATA_W-1:0] mem_rdata_i
);

    addr_u                     line_addr;
    addr_u                     line_addr_q;
    addr_u                     wb_addr_q;
    logic [`DCACHE_DATA_W-1:0] wb_data_q;
    logic                      busy_q;
    logic                      wb_q;
    logic                      done_q;
    logic                      job_fire;
    logic                      beat_fire;

    assign job.job_ready = !busy_q;
    assign job.job_done  = done_q;
    assign job_fire      = job.job_valid && job.job_ready;
    assign beat_fire     = busy_q && mem_ready_i;

    // word aligned line address
    always_comb begin
        line_addr              = job.job_addr;
        line_addr.fields.offset = '0;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            wb_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= beat_fire && !wb_q;
            if (job_fire) begin
                busy_q <= 1'b1;
                wb_q   <= job.wb_needed;
            end else if (beat_fire) begin
                // writeback beat done, refill beat follows
                if (wb_q) begin
                    wb_q <= 1'b0;
                end else begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (job_fire) begin
            line_addr_q <= line_addr;
            wb_addr_q   <= job.wb_addr;
            wb_data_q   <= job.wb_data;
        end
        if (beat_fire && !wb_q) begin
            job.fill_data <= mem_rdata_i;
        end
    end

    // bus fields only move on a completed beat
    assign mem_valid_o = busy_q;
    assign mem_write_o = wb_q;
    assign mem_addr_o  = wb_q ? wb_addr_q.raw : line_addr_q.raw;
    assign mem_wdata_o = wb_data_q;

endmodule

// ==== source/cache_ctrl.sv ====
////////////////////////////////////////
// dcache request controller
// CPU handshake and lookup/hit/miss FSM
////////////////////////////////////////

`timescale 1ns/1ps
`include "dcache_cfg.svh"

module cache_ctrl import dcache_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [`DCACHE_ADDR_W-1:0] req_addr_i,
    input  logic [`DCACHE_DATA_W-1:0] req_wdata_i,
    input  logic [`DCACHE_STRB_W-1:0] req_strb_i,
    input  logic                      req_rd_valid_i,
    input  logic                      req_wr_valid_i,
    output logic                      req_ready_o,
    output logic                      rsp_valid_o,
    output logic [`DCACHE_DATA_W-1:0] rsp_rdata_o,
    store_if.ctrl                     store,
    mem_job_if.ctrl                   job
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    addr_u       req_addr;
    addr_u       wb_addr;
    logic        req_fire;
    logic        relook_q;
    logic        job_sent_q;

    assign req_addr    = req_addr_i;
    assign req_ready_o = (state_q == IDLE);
    assign req_fire    = (req_rd_valid_i || req_wr_valid_i) && req_ready_o;
    assign rsp_valid_o = (state_q == HIT);
    assign rsp_rdata_o = store.rd_data;

    // lookup on acceptance, and again once the refilled line is written
    assign store.lk_valid  = req_fire || relook_q;
    assign store.lk_addr   = req_addr;
    assign store.wr_en     = (state_q == HIT) && req_wr_valid_i;
    assign store.wr_way    = store.hit_way;
    assign store.wr_strb   = req_strb_i;
    assign store.wr_data   = req_wdata_i;
    assign store.touch     = (state_q == HIT);
    assign store.fill_en   = (state_q == MISS) && job.job_done;
    assign store.fill_data = job.fill_data;

    // victim sits in the same set as the request
    always_comb begin
        wb_addr               = req_addr;
        wb_addr.fields.tag    = store.victim_tag;
        wb_addr.fields.offset = '0;
    end

    assign job.job_valid = (state_q == MISS) && !job_sent_q;
    assign job.job_addr  = req_addr;
    assign job.wb_needed = store.victim_dirty;
    assign job.wb_addr   = wb_addr;
    assign job.wb_data   = store.victim_data;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_fire) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (store.rd_done) begin
                    state_d = store.hit ? HIT : MISS;
                end
            end
            HIT: begin
                state_d = IDLE;
            end
            MISS: begin
                if (job.job_done) begin
                    state_d = LOOKUP;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            relook_q   <= 1'b0;
            job_sent_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            relook_q <= store.fill_en;
            // one job per miss
            if (job.job_valid && job.job_ready) begin
                job_sent_q <= 1'b1;
            end else if (job.job_done) begin
                job_sent_q <= 1'b0;
            end
        end
    end

endmodule

// ==== source/dcache_top.sv ====
////////////////////////////////////////
// two-way write-back data cache
// controller, way store, memory port
////////////////////////////////////////

`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic [`DCACHE_ADDR_W-1:0] req_addr_i,
    input  logic [`DCACHE_DATA_W-1:0] req_wdata_i,
    input  logic [`DCACHE_STRB_W-1:0] req_strb_i,
    input  logic                      req_rd_valid_i,
    input  logic                      req_wr_valid_i,
    output logic                      req_ready_o,
    output logic                      rsp_valid_o,
    output logic [`DCACHE_DATA_W-1:0] rsp_rdata_o,
    output logic                      mem_valid_o,
    output logic                      mem_write_o,
    output logic [`DCACHE_ADDR_W-1:0] mem_addr_o,
    output logic [`DCACHE_DATA_W-1:0] mem_wdata_o,
    input  logic                      mem_ready_i,
    input  logic [`DCACHE_DATA_W-1:0] mem_rdata_i
);

    store_if   store_bus ();
    mem_job_if job_bus ();

    cache_ctrl cache_ctrl_inst (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_strb_i     (req_strb_i),
        .req_rd_valid_i (req_rd_valid_i),
        .req_wr_valid_i (req_wr_valid_i),
        .req_ready_o    (req_ready_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_rdata_o    (rsp_rdata_o),
        .store          (store_bus.ctrl),
        .job            (job_bus.ctrl)
    );

    way_store way_store_inst (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .store    (store_bus.store)
    );

    mem_port mem_port_inst (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .job         (job_bus.port),
        .mem_valid_o (mem_valid_o),
        .mem_write_o (mem_write_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ready_i (mem_ready_i),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

// ==== tb/backing_mem.sv ====
////////////////////////////////////////
// memory model behind the cache
// random ready stalls and a beat log
////////////////////////////////////////

`timescale 1ns/1ps

module backing_mem #(
    parameter int SEED = 32'hfe0c
) (
    input  logic        clk,
    input  logic        mem_valid_i,
    input  logic        mem_write_i,
    input  logic [31:0] mem_addr_i,
    input  logic [63:0] mem_wdata_i,
    output logic        mem_ready_o,
    output logic [63:0] mem_rdata_o
);

    logic [63:0] words [logic [31:0]];
    // {write, addr, data} of every completed beat
    logic [96:0] beat_log [$];
    int          seed;
    logic [31:0] r;

    function automatic logic [63:0] read_word(input logic [31:0] a);
        if (words.exists(a)) begin
            return words[a];
        end
        return {a ^ 32'hc3a5_5a3c, ~a};
    endfunction

    // ready and read word change only on the falling edge
    initial begin
        seed        = SEED;
        mem_ready_o = 1'b0;
        mem_rdata_o = '0;
        forever begin
            @(negedge clk);
            r           = $random(seed);
            mem_ready_o = (r[1:0] != 2'b00);
            mem_rdata_o = read_word(mem_addr_i);
        end
    end

    always @(posedge clk) begin
        if (mem_valid_i && mem_ready_o) begin
            if (mem_write_i) begin
                words[mem_addr_i] = mem_wdata_i;
                beat_log.push_back({1'b1, mem_addr_i, mem_wdata_i});
            end else begin
                beat_log.push_back({1'b0, mem_addr_i, mem_rdata_o});
            end
        end
    end

endmodule

// ==== tb/tb_dcache_top.sv ====
////////////////////////////////////////
// testbench for the two-way dcache
// random loads and stores checked
// against a reference memory and set model
////////////////////////////////////////

`timescale 1ns/1ps

module tb_dcache_top;

    localparam int          N_REQ      = 300;
    // cycles per request, covers a dirty miss under heavy stalls
    localparam int          MISS_BOUND = 40;
    localparam logic [22:0] TAG_BASE   = 23'h2a5c31;

    logic        clk;
    logic        arst_n_i;
    logic [31:0] req_addr_i;
    logic [63:0] req_wdata_i;
    logic [7:0]  req_strb_i;
    logic        req_rd_valid_i;
    logic        req_wr_valid_i;
    logic        req_ready_o;
    logic        rsp_valid_o;
    logic [63:0] rsp_rdata_o;
    logic        mem_valid_o;
    logic        mem_write_o;
    logic [31:0] mem_addr_o;
    logic [63:0] mem_wdata_o;
    logic        mem_ready_i;
    logic [63:0] mem_rdata_i;

    int          seed;
    int          errors;
    int          n_hits;
    int          n_wb;
    logic [31:0] r;
    logic [22:0] tag;
    logic [63:0] wdata;
    logic [63:0] ref_mem [logic [31:0]];
    // two-way set model
    logic        m_valid [2][64];
    logic        m_dirty [2][64];
    logic [22:0] m_tag   [2][64];
    logic        m_mru   [64];

    dcache_top dcache_top_inst (.*);

    backing_mem #(.SEED(32'hfe0c)) mem_model (
        .clk         (clk),
        .mem_valid_i (mem_valid_o),
        .mem_write_i (mem_write_o),
        .mem_addr_i  (mem_addr_o),
        .mem_wdata_i (mem_wdata_o),
        .mem_ready_o (mem_ready_i),
        .mem_rdata_o (mem_rdata_i)
    );

    task automatic report_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    function automatic logic [63:0] ref_word(input logic [31:0] a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return {a ^ 32'hc3a5_5a3c, ~a};
    endfunction

    // an empty log reads as all ones, which matches no expected beat
    function automatic logic [96:0] pop_beat();
        if (mem_model.beat_log.size() == 0) begin
            return '1;
        end
        return mem_model.beat_log.pop_front();
    endfunction

    task automatic run_access(input logic wr, input logic [31:0] addr,
                              input logic [63:0] wdata_in, input logic [7:0] strb);
        logic [31:0] line;
        logic [5:0]  idx;
        logic [22:0] ltag;
        logic        exp_hit;
        logic        way;
        logic        exp_wb;
        logic [31:0] wb_line;
        logic [63:0] word;
        logic [96:0] beat;
        int          cycles;

        line    = {addr[31:3], 3'b000};
        idx     = addr[8:3];
        ltag    = addr[31:9];
        exp_hit = 1'b0;
        way     = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == ltag) begin
                exp_hit = 1'b1;
                way     = w[0];
            end
        end
        if (!exp_hit) begin
            way = !m_valid[0][idx] ? 1'b0 : (!m_valid[1][idx] ? 1'b1 : ~m_mru[idx]);
        end
        exp_wb  = !exp_hit && m_valid[way][idx] && m_dirty[way][idx];
        wb_line = {m_tag[way][idx], idx, 3'b000};

        req_addr_i     = addr;
        req_wdata_i    = wdata_in;
        req_strb_i     = strb;
        req_rd_valid_i = !wr;
        req_wr_valid_i = wr;
        assert (req_ready_o) else report_error("req_ready_o low while idle");
        @(posedge clk);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            assert (!req_ready_o) else report_error("req_ready_o high before the response");
        end while (!rsp_valid_o);

        word = ref_word(line);
        if (exp_hit) begin
            n_hits++;
            assert (cycles == 2)
                else report_error($sformatf("hit on %h took %0d cycles", addr, cycles));
        end else begin
            assert (cycles > 2)
                else report_error($sformatf("expected miss on %h answered as a hit", addr));
        end
        if (!wr) begin
            assert (rsp_rdata_o == word)
                else report_error($sformatf("read %h got %h, expected %h",
                                            addr, rsp_rdata_o, word));
        end

        // writeback of the dirty victim, then the refill read
        if (exp_wb) begin
            n_wb++;
            beat = pop_beat();
            assert (beat == {1'b1, wb_line, ref_word(wb_line)})
                else report_error($sformatf("bad writeback beat for victim %h", wb_line));
        end
        if (!exp_hit) begin
            beat = pop_beat();
            assert (beat[96:64] == {1'b0, line})
                else report_error($sformatf("bad refill beat for line %h", line));
        end
        assert (mem_model.beat_log.size() == 0)
            else report_error($sformatf("unexpected memory beats on access %h", addr));
        mem_model.beat_log.delete();

        if (!exp_hit) begin
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
            m_tag[way][idx]   = ltag;
        end
        m_mru[idx] = way;
        if (wr) begin
            m_dirty[way][idx] = 1'b1;
            for (int b = 0; b < 8; b++) begin
                if (strb[b]) begin
                    word[8*b +: 8] = wdata_in[8*b +: 8];
                end
            end
            ref_mem[line] = word;
        end

        // hold the request through the write edge of the hit cycle
        @(negedge clk);
        req_rd_valid_i = 1'b0;
        req_wr_valid_i = 1'b0;
    endtask

    // stalled beat keeps its fields
    assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_write_o)
            && $stable(mem_addr_o) && $stable(mem_wdata_o))
        else report_error("memory beat changed while stalled");

    assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_valid_o && mem_ready_i && mem_write_o |=> mem_valid_o && !mem_write_o)
        else report_error("writeback beat not followed by a refill beat");

    assert property (@(posedge clk) disable iff (!arst_n_i) rsp_valid_o |-> !req_ready_o)
        else report_error("req_ready_o high during a response");

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #((N_REQ * MISS_BOUND + 20) * 4);
        $display("watchdog timeout, the cache stopped answering requests");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        seed           = 32'hfe0c;
        errors         = 0;
        n_hits         = 0;
        n_wb           = 0;
        arst_n_i       = 1'b0;
        req_addr_i     = '0;
        req_wdata_i    = '0;
        req_strb_i     = '0;
        req_rd_valid_i = 1'b0;
        req_wr_valid_i = 1'b0;
        for (int s = 0; s < 64; s++) begin
            m_mru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
                m_tag[w][s]   = '0;
            end
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        assert (req_ready_o && !rsp_valid_o && !mem_valid_o)
            else report_error("outputs not idle after reset");

        // four tags over eight sets, so sets overflow often
        for (int i = 0; i < N_REQ; i++) begin
            r           = $random(seed);
            tag         = TAG_BASE + {21'd0, r[1:0]};
            wdata[63:32] = $random(seed);
            wdata[31:0]  = $random(seed);
            run_access(r[8], {tag, 3'b000, r[4:2], r[7:5]}, wdata, r[23:16]);
        end

        $display("requests %0d, hits %0d, writebacks %0d, errors %0d",
                 N_REQ, n_hits, n_wb, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== dcache_2way.f ====
+incdir+source
source/dcache_pkg.sv
source/store_if.sv
source/mem_job_if.sv
source/way_store.sv
source/mem_port.sv
source/cache_ctrl.sv
source/dcache_top.sv
tb/backing_mem.sv
tb/tb_dcache_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_dcache_top
FILELIST  ?= dcache_2way.f
BUILD_DIR ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the Verilator simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
